// File: Makefile
# Verilator build and run for the power-gating clock unit

TOP := pcgu_tb
SRCS := $(wildcard rtl/*.sv test/*.sv)

.PHONY: all lint clean

# Build, run, and pass only if the pass message is printed
all: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

obj_dir/V$(TOP): src.f $(SRCS)
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f src.f

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps --top-module $(TOP) -f src.f

clean:
	rm -rf obj_dir

// File: rtl/pcgu_aww.sv
// ########################################
// Asynchronous wake widget
// Stretches one active-low wake source and
// hands a synchronized copy to the gate
// controller, one instance per source
// ########################################

`timescale 1ns/1ps

module pcgu_aww (
    input  logic pgcb_clk,
    input  logic pgcb_rst_b,
    // Clock valid back from the gate controller
    input  logic sync_clkvld,
    // Raw wake, asynchronous, active low
    input  logic async_wake_source_b,
    input  logic fscan_rstbypen,
    input  logic fscan_byprst_b,
    // Stretched wake, low as soon as the source falls
    output logic async_wake_extended_b,
    // Synchronized and stretched wake for the controller
    output logic sync_wake_source_b
);

    // Functional clear, reset or an active wake
    logic wake_rst_b;
    // Clear after the scan bypass mux
    logic wake_clr_b;

    // Detector chain, first pair then second pair
    logic dct_q1_b;
    logic dct_q2_b;
    logic det_q1_b;
    logic det_q2_b;

    // Sync path on the detector output
    logic sync_q1_b;
    logic sync_q2_b;

    // Sticky hold, set once clock valid is seen
    logic wake_hold_b;

    // Source low pulls the clear low without a clock
    assign wake_rst_b = pgcb_rst_b & async_wake_source_b;

    // Scan mode hands the clear to the bypass reset
    assign wake_clr_b = fscan_rstbypen ? fscan_byprst_b : wake_rst_b;

    // First pair loads a constant one once the clear lifts
    always_ff @(posedge pgcb_clk or negedge wake_clr_b) begin
        if (!wake_clr_b) begin
            dct_q1_b <= 1'b0;
            dct_q2_b <= 1'b0;
        end else begin
            dct_q1_b <= 1'b1;
            dct_q2_b <= dct_q1_b;
        end
    end

    // Second pair copies the first
    // Detector output rises on the fourth edge after release
    always_ff @(posedge pgcb_clk or negedge wake_clr_b) begin
        if (!wake_clr_b) begin
            det_q1_b <= 1'b0;
            det_q2_b <= 1'b0;
        end else begin
            det_q1_b <= dct_q2_b;
            det_q2_b <= det_q1_b;
        end
    end

    // Two-flop sync on the detector, reset by pgcb_rst_b only
    // A wake reaches sync_q2_b within two edges
    always_ff @(posedge pgcb_clk or negedge pgcb_rst_b) begin
        if (!pgcb_rst_b) begin
            sync_q1_b <= 1'b0;
            sync_q2_b <= 1'b0;
        end else begin
            sync_q1_b <= det_q2_b;
            sync_q2_b <= sync_q1_b;
        end
    end

    // Hold clears while the sync path shows a wake
    // Sets on clock valid and then keeps itself until the next wake
    // So a released wake stays active until the clock is known good
    always_ff @(posedge pgcb_clk or negedge pgcb_rst_b) begin
        if (!pgcb_rst_b) begin
            wake_hold_b <= 1'b0;
        end else begin
            wake_hold_b <= (sync_clkvld | wake_hold_b) & sync_q2_b;
        end
    end

    // Falls with the source, rises only after release and clock valid
    assign async_wake_extended_b = det_q2_b & wake_hold_b;

    // Conservative wake term for the gate decision
    assign sync_wake_source_b = sync_q2_b & wake_hold_b;

endmodule

// File: rtl/pcgu_gate_ctrl.sv
// ########################################
// Gate controller
// Gates the clock after a run of idle
// cycles, ungates on any synced wake and
// reports clock valid after a fixed delay
// ########################################

`timescale 1ns/1ps

module pcgu_gate_ctrl #(
    parameter int             NUM_WAKE   = 4,
    parameter pcgu_pkg::cnt_t HYST_CYC   = pcgu_pkg::DEF_HYST_CYC,
    parameter pcgu_pkg::cnt_t CLKVLD_DLY = pcgu_pkg::DEF_CLKVLD_DLY
) (
    input  logic                pgcb_clk,
    input  logic                pgcb_rst_b,
    // Synced wakes from the widgets, active low
    input  logic [NUM_WAKE-1:0] sync_wake_b,
    // IP reports nothing to do
    input  logic                ip_idle,
    // High in ST_ON and ST_HYST
    output logic                sync_clkvld,
    // High in ST_GATED
    output logic                clk_gated
);

    // Current and next state
    pcgu_pkg::gate_state_t state;
    pcgu_pkg::gate_state_t state_nxt;

    // Shared counter, clock-valid delay or hysteresis
    pcgu_pkg::cnt_t cnt;
    pcgu_pkg::cnt_t cnt_nxt;
    pcgu_pkg::cnt_t cnt_inc;

    // No widget is asking for the clock
    logic no_wake;
    // Gating is allowed this cycle
    logic idle_cond;
    // Count has reached its target on this edge
    logic clkvld_done;
    logic hyst_done;

    // All bits high means no wake anywhere
    assign no_wake = &sync_wake_b;

    assign idle_cond = ip_idle & no_wake;

    // Counter value after this edge
    assign cnt_inc = cnt + pcgu_pkg::cnt_t'(1);

    // Reached on edge CLKVLD_DLY after entering ST_UNGATE
    assign clkvld_done = (cnt_inc >= CLKVLD_DLY);

    // Reached after HYST_CYC idle cycles in ST_HYST
    assign hyst_done = (cnt_inc >= HYST_CYC);

    // Next state and counter
    always_comb begin
        state_nxt = state;
        cnt_nxt   = cnt;

        unique case (state)
            pcgu_pkg::ST_UNGATE: begin
                // Clock running again, wait for it to settle
                if (clkvld_done) begin
                    state_nxt = pcgu_pkg::ST_ON;
                    cnt_nxt   = '0;
                end else begin
                    cnt_nxt = cnt_inc;
                end
            end

            pcgu_pkg::ST_ON: begin
                // First idle sample starts the hysteresis
                if (idle_cond) begin
                    state_nxt = pcgu_pkg::ST_HYST;
                    cnt_nxt   = '0;
                end
            end

            pcgu_pkg::ST_HYST: begin
                if (!idle_cond) begin
                    // Busy again or a wake, full count needed next time
                    state_nxt = pcgu_pkg::ST_ON;
                    cnt_nxt   = '0;
                end else if (hyst_done) begin
                    state_nxt = pcgu_pkg::ST_GATED;
                    cnt_nxt   = '0;
                end else begin
                    cnt_nxt = cnt_inc;
                end
            end

            pcgu_pkg::ST_GATED: begin
                // Only a wake can reopen the clock
                // ip_idle is ignored here
                if (!no_wake) begin
                    state_nxt = pcgu_pkg::ST_UNGATE;
                    cnt_nxt   = '0;
                end
            end

            default: begin
                state_nxt = pcgu_pkg::ST_UNGATE;
                cnt_nxt   = '0;
            end
        endcase
    end

    // State and counter registers
    always_ff @(posedge pgcb_clk or negedge pgcb_rst_b) begin
        if (!pgcb_rst_b) begin
            state <= pcgu_pkg::ST_UNGATE;
            cnt   <= '0;
        end else begin
            state <= state_nxt;
            cnt   <= cnt_nxt;
        end
    end

    // Outputs decoded from next state, so they change on the same
    // edge as the state itself
    always_ff @(posedge pgcb_clk or negedge pgcb_rst_b) begin
        if (!pgcb_rst_b) begin
            sync_clkvld <= 1'b0;
            clk_gated   <= 1'b0;
        end else begin
            sync_clkvld <= (state_nxt == pcgu_pkg::ST_ON) ||
                           (state_nxt == pcgu_pkg::ST_HYST);
            clk_gated   <= (state_nxt == pcgu_pkg::ST_GATED);
        end
    end

endmodule

// File: rtl/pcgu_pkg.sv
// ########################################
// Shared types and timing defaults for the
// power-gating clock unit
// Referenced by scoped name from the RTL
// and the testbench
// ########################################

package pcgu_pkg;

    // Count width for hysteresis and clock-valid delay
    typedef logic [7:0] cnt_t;

    // Gate controller states
    typedef enum logic [1:0] {
        // Clock running, waiting out the clock-valid delay
        ST_UNGATE = 2'b00,
        // Clock valid, IP busy or a wake pending
        ST_ON     = 2'b01,
        // Idle seen, counting toward gating
        ST_HYST   = 2'b10,
        // Clock gated, waiting for a wake
        ST_GATED  = 2'b11
    } gate_state_t;

    // Idle cycles needed before the clock is gated
    localparam cnt_t DEF_HYST_CYC   = 8'd16;

    // Cycles from ungate start to sync_clkvld
    localparam cnt_t DEF_CLKVLD_DLY = 8'd3;

endpackage

// File: rtl/pcgu_top.sv
// ########################################
// Power-gating clock unit top level
// One wake widget per source feeding one
// gate controller, plus the combined
// asynchronous wake for outside logic
// ########################################

`timescale 1ns/1ps

module pcgu_top #(
    parameter int             NUM_WAKE   = 4,
    parameter pcgu_pkg::cnt_t HYST_CYC   = pcgu_pkg::DEF_HYST_CYC,
    parameter pcgu_pkg::cnt_t CLKVLD_DLY = pcgu_pkg::DEF_CLKVLD_DLY
) (
    input  logic                pgcb_clk,
    input  logic                pgcb_rst_b,
    // Wake sources, asynchronous, active low
    input  logic [NUM_WAKE-1:0] wake_source_b,
    // Synchronous idle level from the IP
    input  logic                ip_idle,
    // Scan reset bypass
    input  logic                fscan_rstbypen,
    input  logic                fscan_byprst_b,
    // Combined stretched wake, active low
    output logic                async_wake_b,
    output logic                sync_clkvld,
    output logic                clk_gated
);

    // Per-widget stretched wakes
    logic [NUM_WAKE-1:0] async_wake_extended_b;
    // Per-widget synced wakes into the controller
    logic [NUM_WAKE-1:0] sync_wake_source_b;

    // One widget per source
    for (genvar g = 0; g < NUM_WAKE; g++) begin : g_aww
        pcgu_aww i_pcgu_aww (
            .pgcb_clk              (pgcb_clk),
            .pgcb_rst_b            (pgcb_rst_b),
            .sync_clkvld           (sync_clkvld),
            .async_wake_source_b   (wake_source_b[g]),
            .fscan_rstbypen        (fscan_rstbypen),
            .fscan_byprst_b        (fscan_byprst_b),
            .async_wake_extended_b (async_wake_extended_b[g]),
            .sync_wake_source_b    (sync_wake_source_b[g])
        );
    end

    // Gating decision from the synced wakes and idle
    pcgu_gate_ctrl #(
        .NUM_WAKE   (NUM_WAKE),
        .HYST_CYC   (HYST_CYC),
        .CLKVLD_DLY (CLKVLD_DLY)
    ) i_pcgu_gate_ctrl (
        .pgcb_clk    (pgcb_clk),
        .pgcb_rst_b  (pgcb_rst_b),
        .sync_wake_b (sync_wake_source_b),
        .ip_idle     (ip_idle),
        .sync_clkvld (sync_clkvld),
        .clk_gated   (clk_gated)
    );

    // Any stretched wake pulls the combined wake low
    // No clock in this path, usable while gated
    assign async_wake_b = &async_wake_extended_b;

endmodule

// File: src.f
rtl/pcgu_pkg.sv
rtl/pcgu_aww.sv
rtl/pcgu_gate_ctrl.sv
rtl/pcgu_top.sv
test/pcgu_tb.sv

// File: test/pcgu_tb.sv
// ########################################
// Testbench for the power-gating clock unit
// Reset, idle gating, hysteresis abort,
// wake while gated, scan bypass and random
// wakes against a reference wake model
// ########################################

`timescale 1ns/1ps

module pcgu_tb;

    localparam int NUM_WAKE     = 4;
    localparam int HYST_CYC     = int'(pcgu_pkg::DEF_HYST_CYC);
    localparam int CLKVLD_DLY   = int'(pcgu_pkg::DEF_CLKVLD_DLY);
    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DLY    = 2;
    localparam int NUM_EPISODES = 20;
    localparam int QUIET_EDGES  = 16;
    // Run budget of 40 tests at HYST_CYC + 40 cycles each
    localparam int NUM_TESTS    = 40;
    localparam int WDOG_NS      = NUM_TESTS * (HYST_CYC + 40) * CLK_PERIOD;

    // Which output wait_level watches
    localparam int SIG_VLD   = 0;
    localparam int SIG_GATED = 1;
    localparam int SIG_ASYNC = 2;

    logic                pgcb_clk;
    logic                pgcb_rst_b;
    logic [NUM_WAKE-1:0] wake_source_b;
    logic                ip_idle;
    logic                fscan_rstbypen;
    logic                fscan_byprst_b;
    logic                async_wake_b;
    logic                sync_clkvld;
    logic                clk_gated;

    // Per-source reference wake model
    int                  rel_cnt [NUM_WAKE];
    logic [NUM_WAKE-1:0] vld_seen;
    // Edges each source has been low
    int                  low_cnt [NUM_WAKE];
    // Remaining low edges of a random pulse
    int                  low_left [NUM_WAKE];

    int          val_errs;
    int          other_errs;
    logic        mon_en;
    logic [31:0] rng_state;

    pcgu_top #(
        .NUM_WAKE   (NUM_WAKE),
        .HYST_CYC   (pcgu_pkg::DEF_HYST_CYC),
        .CLKVLD_DLY (pcgu_pkg::DEF_CLKVLD_DLY)
    ) i_pcgu_top (
        .pgcb_clk       (pgcb_clk),
        .pgcb_rst_b     (pgcb_rst_b),
        .wake_source_b  (wake_source_b),
        .ip_idle        (ip_idle),
        .fscan_rstbypen (fscan_rstbypen),
        .fscan_byprst_b (fscan_byprst_b),
        .async_wake_b   (async_wake_b),
        .sync_clkvld    (sync_clkvld),
        .clk_gated      (clk_gated)
    );

    initial begin
        pgcb_clk = 1'b0;
        forever #(CLK_PERIOD / 2) pgcb_clk = ~pgcb_clk;
    end

    // Watchdog
    initial begin
        #(WDOG_NS);
        $display("Error: watchdog timeout, test did not finish");
        $display("FAIL: see errors above");
        $finish;
    end

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Clear each widget sees
    // Scan bypass overrides reset and source
    function automatic logic [NUM_WAKE-1:0] wake_clear_b();
        if (fscan_rstbypen) begin
            return {NUM_WAKE{fscan_byprst_b}};
        end
        return wake_source_b & {NUM_WAKE{pgcb_rst_b}};
    endfunction

    // Expected combined wake
    // Low while any clear is active, or released under 4 edges ago,
    // or no clock valid seen since the release
    function automatic logic exp_async_wake();
        logic [NUM_WAKE-1:0] clr_b;
        logic                exp;
        clr_b = wake_clear_b();
        exp   = 1'b1;
        for (int i = 0; i < NUM_WAKE; i++) begin
            if (!clr_b[i] || rel_cnt[i] < 4 || !vld_seen[i]) begin
                exp = 1'b0;
            end
        end
        return exp;
    endfunction

    function automatic logic dut_level(input int which);
        case (which)
            SIG_VLD:   return sync_clkvld;
            SIG_GATED: return clk_gated;
            default:   return async_wake_b;
        endcase
    endfunction

    function automatic string sig_name(input int which);
        case (which)
            SIG_VLD:   return "sync_clkvld";
            SIG_GATED: return "clk_gated";
            default:   return "async_wake_b";
        endcase
    endfunction

    // Rising edge plus the drive delay
    task automatic next_edge();
        @(posedge pgcb_clk);
        #(DRIVE_DLY);
    endtask

    task automatic check_val(input string test, input string what,
                             input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error %s: %s expected %0b actual %0b", test, what, exp, act);
            val_errs++;
        end
    endtask

    task automatic check_int(input string test, input string what,
                             input int exp, input int act);
        if (act != exp) begin
            $display("** Error %s: %s expected %0d actual %0d", test, what, exp, act);
            val_errs++;
        end
    endtask

    // Step edges until an output reaches a level or the bound runs out
    task automatic wait_level(input int which, input logic level, input int max_edges,
                              input string test, output int edges);
        edges = 0;
        while (dut_level(which) !== level && edges < max_edges) begin
            next_edge();
            edges++;
        end
        if (dut_level(which) !== level) begin
            $display("%s: %s did not go to %0b within %0d clock edges",
                     test, sig_name(which), level, max_edges);
            other_errs++;
        end
    endtask

    // Count edges until clk_gated
    // First edge is the one sampling idle
    task automatic count_to_gate(output int edges, output logic prev_vld);
        edges = 0;
        do begin
            prev_vld = sync_clkvld;
            next_edge();
            edges++;
        end while (!clk_gated && edges < HYST_CYC + 8);
    endtask

    // Model update and per-edge rules on pre-edge values
    always @(posedge pgcb_clk) begin : model_monitor
        logic [NUM_WAKE-1:0] clr_b;
        clr_b = wake_clear_b();
        for (int i = 0; i < NUM_WAKE; i++) begin
            if (mon_en) begin
                if (!wake_source_b[i]) begin
                    low_cnt[i] = low_cnt[i] + 1;
                end else begin
                    low_cnt[i] = 0;
                end
                // A wake held 4 edges must have ungated the clock
                if (low_cnt[i] >= 4) begin
                    check_val("edge_monitor", "clk_gated with a long wake", 1'b0, clk_gated);
                end
            end
            if (!clr_b[i]) begin
                rel_cnt[i]  = 0;
                vld_seen[i] = 1'b0;
            end else begin
                if (rel_cnt[i] >= 4 && sync_clkvld) begin
                    vld_seen[i] = 1'b1;
                end
                if (rel_cnt[i] < 1000) begin
                    rel_cnt[i] = rel_cnt[i] + 1;
                end
            end
        end
        // Any low source pulls the combined wake low
        if (mon_en && !(&wake_source_b)) begin
            check_val("edge_monitor", "async_wake_b with a source low", 1'b0, async_wake_b);
        end
    end

    initial begin : stimulus
        int   n;
        int   k;
        int   len;
        logic prev_vld;

        pgcb_rst_b     = 1'b0;
        wake_source_b  = '1;
        ip_idle        = 1'b0;
        fscan_rstbypen = 1'b0;
        fscan_byprst_b = 1'b1;
        val_errs       = 0;
        other_errs     = 0;
        mon_en         = 1'b0;
        rng_state      = 32'hd6e3;
        vld_seen       = '0;
        for (int i = 0; i < NUM_WAKE; i++) begin
            rel_cnt[i]  = 0;
            low_cnt[i]  = 0;
            low_left[i] = 0;
        end

        repeat (8) @(posedge pgcb_clk);
        #(DRIVE_DLY);
        pgcb_rst_b = 1'b1;
        mon_en     = 1'b1;

        // Reset and clock valid
        wait_level(SIG_VLD, 1'b1, CLKVLD_DLY + 8, "reset", n);
        check_val("reset", "clk_gated", 1'b0, clk_gated);
        check_val("reset", "async_wake_b at clock valid", exp_async_wake(), async_wake_b);
        wait_level(SIG_ASYNC, 1'b1, 16, "reset", n);
        check_val("reset", "async_wake_b", exp_async_wake(), async_wake_b);
        check_val("reset", "clk_gated", 1'b0, clk_gated);

        // Idle gating
        ip_idle = 1'b1;
        count_to_gate(n, prev_vld);
        check_int("idle_gating", "edges to clk_gated", HYST_CYC + 1, n);
        check_val("idle_gating", "clk_gated", 1'b1, clk_gated);
        check_val("idle_gating", "sync_clkvld before gating", 1'b1, prev_vld);
        check_val("idle_gating", "sync_clkvld at gating", 1'b0, sync_clkvld);

        // Wake on one source while gated
        k = int'(xorshift32() % NUM_WAKE);
        wake_source_b[k] = 1'b0;
        ip_idle          = 1'b0;
        #1;
        check_val("async_wake", "async_wake_b before any edge", exp_async_wake(), async_wake_b);
        wait_level(SIG_GATED, 1'b0, 4, "async_wake", n);
        wait_level(SIG_VLD, 1'b1, CLKVLD_DLY + 4, "async_wake", n);
        check_int("async_wake", "edges from ungate to sync_clkvld", CLKVLD_DLY, n);
        wake_source_b[k] = 1'b1;
        #1;
        check_val("async_wake", "async_wake_b at release", exp_async_wake(), async_wake_b);
        repeat (3) begin
            next_edge();
            check_val("async_wake", "async_wake_b after release", exp_async_wake(),
                      async_wake_b);
        end
        wait_level(SIG_ASYNC, 1'b1, 16, "async_wake", n);
        check_val("async_wake", "async_wake_b", exp_async_wake(), async_wake_b);
        check_val("async_wake", "sync_clkvld", 1'b1, sync_clkvld);

        // Hysteresis abort half way through
        ip_idle = 1'b1;
        repeat (HYST_CYC / 2) next_edge();
        check_val("hyst_abort", "clk_gated mid count", 1'b0, clk_gated);
        ip_idle = 1'b0;
        next_edge();
        ip_idle = 1'b1;
        count_to_gate(n, prev_vld);
        check_int("hyst_abort", "edges from restart to clk_gated", HYST_CYC + 1, n);

        // Scan bypass from the gated state
        fscan_rstbypen = 1'b1;
        fscan_byprst_b = 1'b0;
        ip_idle        = 1'b0;
        #1;
        check_val("scan_bypass", "async_wake_b", exp_async_wake(), async_wake_b);
        wait_level(SIG_GATED, 1'b0, 4, "scan_bypass", n);
        // Sources have no say while bypassed
        wake_source_b[0] = 1'b0;
        #1;
        check_val("scan_bypass", "async_wake_b source low", exp_async_wake(), async_wake_b);
        next_edge();
        wake_source_b[0] = 1'b1;
        #1;
        check_val("scan_bypass", "async_wake_b source high", exp_async_wake(), async_wake_b);
        next_edge();
        fscan_byprst_b = 1'b1;
        wait_level(SIG_ASYNC, 1'b1, 20, "scan_bypass", n);
        check_val("scan_bypass", "async_wake_b restored", exp_async_wake(), async_wake_b);
        fscan_rstbypen = 1'b0;
        #1;
        check_val("scan_bypass", "async_wake_b scan off", exp_async_wake(), async_wake_b);

        // Random wake pulses over mostly idle periods
        for (int ep = 0; ep < NUM_EPISODES; ep++) begin
            len = 20 + int'(xorshift32() % 40);
            repeat (len) begin
                next_edge();
                ip_idle = (xorshift32() % 8) != 0;
                for (int i = 0; i < NUM_WAKE; i++) begin
                    if (low_left[i] > 0) begin
                        low_left[i] = low_left[i] - 1;
                        if (low_left[i] == 0) begin
                            wake_source_b[i] = 1'b1;
                        end
                    end else if ((xorshift32() % 24) == 0) begin
                        low_left[i]      = 1 + int'(xorshift32() % 8);
                        wake_source_b[i] = 1'b0;
                    end
                end
                #1;
                if (!(&wake_source_b)) begin
                    check_val("random_wake", "async_wake_b", exp_async_wake(), async_wake_b);
                end
            end
            // Quiet window with every source released and the IP busy
            next_edge();
            wake_source_b = '1;
            ip_idle       = 1'b0;
            for (int i = 0; i < NUM_WAKE; i++) begin
                low_left[i] = 0;
            end
            repeat (QUIET_EDGES) next_edge();
            check_val("random_quiet", "async_wake_b", exp_async_wake(), async_wake_b);
        end

        $display("Errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
